/* all.f */
+incdir+dv
source/ooo_exec_pkg.sv
source/arithmetic_unit.sv
source/multiply_unit.sv
source/divide_unit.sv
source/branch_resolution_unit.sv
source/ooo_execute_stage.sv
dv/tb_ooo_execute_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f all.f \
  --top-module tb_ooo_execute_stage -Mdir obj_dir

status=0
./obj_dir/Vtb_ooo_execute_stage > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Test failed, see sim.log"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Simulation did not complete, see sim.log"
  exit 1
fi
echo "Test passed"

/* dv/exec_model.svh */
/*
  Execute stage reference model
  Expected results of the ALU, multiply, divide, branch and jump paths
*/
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
  word_t sign_fill;
  // Upper bits that an arithmetic shift fills with the sign
  sign_fill = a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'd0;
  case (op)
    ALU_ADD:  return a + b;
    ALU_SUB:  return a - b;
    ALU_AND:  return a & b;
    ALU_OR:   return a | b;
    ALU_XOR:  return a ^ b;
    ALU_SLL:  return a << b[4:0];
    ALU_SRL:  return a >> b[4:0];
    ALU_SRA:  return (a >> b[4:0]) | sign_fill;
    // Differing signs, the negative one is smaller
    ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
    ALU_SLTU: return {31'd0, a < b};
    default:  return '0;
  endcase
endfunction

function automatic word_t mul_model(mul_op_t op, word_t a, word_t b);
  logic [63:0] ext_a;
  logic [63:0] ext_b;
  logic [63:0] prod;
  ext_a = {32'd0, a};
  ext_b = {32'd0, b};
  if ((op == MUL_HSS) || (op == MUL_HSU)) begin
    ext_a = {{32{a[31]}}, a};
  end
  if (op == MUL_HSS) begin
    ext_b = {{32{b[31]}}, b};
  end
  // Modulo 2^64 product is exact for the low 64 bits
  prod = ext_a * ext_b;
  return (op == MUL_LO) ? prod[31:0] : prod[63:32];
endfunction

function automatic word_t div_model(div_op_t op, word_t a, word_t b);
  logic  is_signed;
  logic  is_rem;
  word_t quo;
  word_t rem;
  is_signed = (op == DIV_S) || (op == REM_S);
  is_rem    = (op == REM_S) || (op == REM_U);
  if (b == 32'd0) begin
    quo = 32'hFFFF_FFFF;
    rem = a;
  end else if (is_signed && (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF)) begin
    quo = a;
    rem = 32'd0;
  end else if (is_signed) begin
    quo = $signed(a) / $signed(b);
    rem = $signed(a) % $signed(b);
  end else begin
    quo = a / b;
    rem = a % b;
  end
  return is_rem ? rem : quo;
endfunction

function automatic logic taken_model(br_type_t t, word_t a, word_t b);
  case (t)
    BR_EQ:   return a == b;
    BR_NE:   return a != b;
    BR_LT:   return $signed(a) < $signed(b);
    BR_GE:   return $signed(a) >= $signed(b);
    BR_LTU:  return a < b;
    BR_GEU:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic word_t resolved_model(logic taken, word_t pc, word_t imm);
  return taken ? pc + imm : pc + 32'd4;
endfunction

function automatic word_t jump_model(logic j_sel, word_t pc, word_t rs1, word_t imm);
  word_t target;
  target    = (j_sel ? pc : rs1) + imm;
  target[0] = 1'b0;
  return target;
endfunction

`endif

/* dv/tb_ooo_execute_stage.sv */
/*
  Execute stage testbench
  Random issues to every unit, checked against the reference model
*/
`timescale 1ns/1ns

module tb_ooo_execute_stage;
  import ooo_exec_pkg::*;

  `include "exec_model.svh"

  localparam int MUL_LATENCY = 2;

  // Expected multiply result and the cycle it must reach commit
  typedef struct packed {
    int       due;
    reg_idx_t rd;
    word_t    data;
  } mul_exp_t;

  logic      CLK, nRST, flush, intr, intr_taken;
  ex_issue_t issue;
  commit_t   commit;
  logic      mispredict, busy_du;
  word_t     brj_addr;

  integer    seed;
  int        cycle_cnt;
  int        k;
  mul_exp_t  mul_q [$];
  ex_issue_t iss;
  logic      du_pending, intr_model;
  logic      exp_flushed, exp_au_wen, exp_branch, exp_jump, exp_taken, exp_intr_seen;
  logic      exp_prediction;
  reg_idx_t  exp_au_rd;
  word_t     exp_au_data, exp_pc, exp_br_addr, exp_j_addr;

  ooo_execute_stage #(
    .MUL_LATENCY (MUL_LATENCY)
  ) DUT (
    .CLK        (CLK),
    .nRST       (nRST),
    .issue      (issue),
    .flush      (flush),
    .intr       (intr),
    .intr_taken (intr_taken),
    .commit     (commit),
    .mispredict (mispredict),
    .brj_addr   (brj_addr),
    .busy_du    (busy_du)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic ex_issue_t rand_issue(fu_t fu);
    ex_issue_t r;
    r.fu         = fu;
    r.alu_op     = alu_op_t'(rand_below(10));
    r.mul_op     = mul_op_t'(rand_below(4));
    r.div_op     = div_op_t'(rand_below(4));
    r.rs1_data   = $random(seed);
    r.rs2_data   = $random(seed);
    r.rd         = reg_idx_t'(rand_below(32));
    r.pc         = $random(seed);
    r.imm        = $random(seed);
    r.br_type    = br_type_t'(rand_below(6));
    r.prediction = (rand_below(2) == 1);
    r.j_sel      = (rand_below(2) == 1);
    return r;
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // Commit record after one edge against the expectations of the last issue
  task automatic check_slots();
    if (exp_flushed) begin
      check_value("commit cleared by flush", 0, 64'(|commit));
    end else begin
      check_value("wb_au wen", 64'(exp_au_wen), 64'(commit.wb_au.wen));
      if (exp_au_wen) begin
        check_value("wb_au rd", 64'(exp_au_rd), 64'(commit.wb_au.rd));
        check_value("wb_au wdata", 64'(exp_au_data), 64'(commit.wb_au.wdata));
      end
      check_value("commit pc", 64'(exp_pc), 64'(commit.pc));
      check_value("branch_instr", 64'(exp_branch), 64'(commit.branch_instr));
      check_value("jump_instr", 64'(exp_jump), 64'(commit.jump_instr));
      check_value("prediction", 64'(exp_prediction), 64'(commit.prediction));
      if (exp_branch) begin
        check_value("branch_taken", 64'(exp_taken), 64'(commit.branch_taken));
        check_value("br_resolved_addr", 64'(exp_br_addr), 64'(commit.br_resolved_addr));
      end
      if (exp_jump) begin
        check_value("jump_addr", 64'(exp_j_addr), 64'(commit.jump_addr));
      end
      check_value("intr_seen", 64'(exp_intr_seen), 64'(commit.intr_seen));
    end
    if ((mul_q.size() > 0) && (mul_q[0].due == cycle_cnt)) begin
      check_value("wb_mu wen", 1, 64'(commit.wb_mu.wen));
      check_value("wb_mu rd", 64'(mul_q[0].rd), 64'(commit.wb_mu.rd));
      check_value("wb_mu wdata", 64'(mul_q[0].data), 64'(commit.wb_mu.wdata));
      mul_q.delete(0);
    end else begin
      check_value("wb_mu wen idle", 0, 64'(commit.wb_mu.wen));
    end
    if (!du_pending) begin
      check_value("wb_du wen idle", 0, 64'(commit.wb_du.wen));
    end
  endtask

  // Drives one cycle from a falling edge to the next and checks the result
  task automatic apply_cycle(ex_issue_t op, logic fl, logic irq, logic irq_taken);
    logic     taken;
    word_t    br_addr;
    word_t    j_addr;
    mul_exp_t m;
    issue      = op;
    flush      = fl;
    intr       = irq;
    intr_taken = irq_taken;
    taken   = taken_model(op.br_type, op.rs1_data, op.rs2_data);
    br_addr = resolved_model(taken, op.pc, op.imm);
    j_addr  = jump_model(op.j_sel, op.pc, op.rs1_data, op.imm);
    #1;
    check_value("mispredict", 64'((op.fu == FU_BRANCH) && (op.prediction != taken)),
                64'(mispredict));
    check_value("brj_addr", 64'((op.fu == FU_JUMP) ? j_addr : br_addr), 64'(brj_addr));
    exp_flushed    = fl;
    exp_au_wen     = (op.fu == FU_ALU);
    exp_au_rd      = op.rd;
    exp_au_data    = alu_model(op.alu_op, op.rs1_data, op.rs2_data);
    exp_pc         = op.pc;
    exp_branch     = (op.fu == FU_BRANCH);
    exp_jump       = (op.fu == FU_JUMP);
    exp_prediction = op.prediction;
    exp_taken      = taken;
    exp_br_addr    = br_addr;
    exp_j_addr     = j_addr;
    exp_intr_seen  = intr_model;
    if (fl) begin
      mul_q.delete();
      du_pending = 1'b0;
      intr_model = 1'b0;
    end else begin
      if (irq) begin
        intr_model = 1'b1;
      end else if (irq_taken) begin
        intr_model = 1'b0;
      end
      if (op.fu == FU_MUL) begin
        m.due  = cycle_cnt + MUL_LATENCY + 1;
        m.rd   = op.rd;
        m.data = mul_model(op.mul_op, op.rs1_data, op.rs2_data);
        mul_q.push_back(m);
      end
    end
    @(negedge CLK);
    cycle_cnt++;
    check_slots();
  endtask

  task automatic issue_op(ex_issue_t op);
    apply_cycle(op, 1'b0, 1'b0, 1'b0);
  endtask

  // ALU work keeps flowing while the divider runs
  task automatic wait_divide(word_t exp_data, reg_idx_t exp_rd);
    int   waited;
    logic busy_dropped;
    waited       = 0;
    busy_dropped = 1'b0;
    check_value("busy_du after divide issue", 1, 64'(busy_du));
    while (!commit.wb_du.wen) begin
      if (waited == 40) begin
        $display("Timeout: no divide result within 40 cycles");
        $display("SIMULATION FAILED");
        $fatal(1);
      end
      // Busy may only be low in the last cycle before the result
      check_value("busy_du low before last cycle", 0, 64'(busy_dropped));
      busy_dropped = busy_dropped | !busy_du;
      if (rand_below(2) == 1) begin
        issue_op(rand_issue(FU_ALU));
      end else begin
        issue_op('0);
      end
      waited++;
    end
    check_value("busy_du fell before result", 1, 64'(busy_dropped));
    check_value("wb_du rd", 64'(exp_rd), 64'(commit.wb_du.rd));
    check_value("wb_du wdata", 64'(exp_data), 64'(commit.wb_du.wdata));
    check_value("busy_du at result", 0, 64'(busy_du));
    du_pending = 1'b0;
  endtask

  initial begin
    seed       = 63292;
    cycle_cnt  = 0;
    du_pending = 1'b0;
    intr_model = 1'b0;
    nRST       = 1'b0;
    flush      = 1'b0;
    intr       = 1'b0;
    intr_taken = 1'b0;
    issue      = '0;
    repeat (10) @(negedge CLK);
    check_value("wb_au wen in reset", 0, 64'(commit.wb_au.wen));
    check_value("wb_mu wen in reset", 0, 64'(commit.wb_mu.wen));
    check_value("wb_du wen in reset", 0, 64'(commit.wb_du.wen));
    check_value("intr_seen in reset", 0, 64'(commit.intr_seen));
    check_value("busy_du in reset", 0, 64'(busy_du));
    nRST = 1'b1;

    repeat (200) issue_op(rand_issue(FU_ALU));

    // Mostly back-to-back multiplies
    repeat (150) begin
      if (rand_below(5) == 0) begin
        issue_op(rand_issue(FU_ALU));
      end else begin
        issue_op(rand_issue(FU_MUL));
      end
    end
    repeat (MUL_LATENCY + 1) issue_op('0);
    check_value("multiply results outstanding", 0, 64'(mul_q.size()));

    // Zero divisor, signed overflow and small divisors in turn
    for (k = 0; k < 40; k++) begin
      iss = rand_issue(FU_DIV);
      case (k % 4)
        0: begin
          iss.rs2_data = '0;
        end
        1: begin
          iss.rs1_data = 32'h8000_0000;
          iss.rs2_data = 32'hFFFF_FFFF;
          iss.div_op   = ((k % 8) == 1) ? DIV_S : REM_S;
        end
        2: begin
          iss.rs2_data = iss.rs2_data >> rand_below(32);
        end
        default: begin
        end
      endcase
      du_pending = 1'b1;
      issue_op(iss);
      wait_divide(div_model(iss.div_op, iss.rs1_data, iss.rs2_data), iss.rd);
    end

    repeat (200) begin
      iss = rand_issue((rand_below(2) == 1) ? FU_BRANCH : FU_JUMP);
      if (rand_below(4) == 0) begin
        iss.rs2_data = iss.rs1_data;
      end
      issue_op(iss);
    end

    // Interrupt latch set and clear
    apply_cycle('0, 1'b0, 1'b1, 1'b0);
    repeat (2) issue_op('0);
    check_value("intr_seen after intr", 1, 64'(commit.intr_seen));
    apply_cycle('0, 1'b0, 1'b0, 1'b1);
    repeat (2) issue_op('0);
    check_value("intr_seen after intr_taken", 0, 64'(commit.intr_seen));

    // Flush with a pending interrupt and two multiplies in flight
    apply_cycle('0, 1'b0, 1'b1, 1'b0);
    issue_op(rand_issue(FU_MUL));
    issue_op(rand_issue(FU_MUL));
    apply_cycle('0, 1'b1, 1'b0, 1'b0);
    repeat (MUL_LATENCY + 2) issue_op('0);
    check_value("intr_seen after flush", 0, 64'(commit.intr_seen));

    // Divide aborted part way through
    du_pending = 1'b1;
    issue_op(rand_issue(FU_DIV));
    repeat (5) issue_op('0);
    check_value("busy_du before abort", 1, 64'(busy_du));
    apply_cycle('0, 1'b1, 1'b0, 1'b0);
    check_value("busy_du after flush", 0, 64'(busy_du));
    repeat (40) issue_op('0);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* source/ooo_execute_stage.sv */
/*
  Out-of-order execute stage
  Routes each issue to its unit, keeps the interrupt latch and registers
  the execute-to-commit record, misprediction goes out in the issue cycle
*/
`timescale 1ns/1ns

module ooo_execute_stage #(
  parameter int MUL_LATENCY = 2
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  ooo_exec_pkg::ex_issue_t issue,
  input  logic                    flush,
  input  logic                    intr,
  input  logic                    intr_taken,
  output ooo_exec_pkg::commit_t   commit,
  output logic                    mispredict,
  output ooo_exec_pkg::word_t     brj_addr,
  output logic                    busy_du
);
  import ooo_exec_pkg::*;

  logic    alu_start, mul_start, div_start, br_start, jump_start;
  logic    intr_latch;
  wb_t     wb_au, wb_mu, wb_du;
  br_res_t br_res;

  // Unit strobes from the fu code
  assign alu_start  = (issue.fu == FU_ALU);
  assign mul_start  = (issue.fu == FU_MUL);
  assign div_start  = (issue.fu == FU_DIV);
  assign br_start   = (issue.fu == FU_BRANCH);
  assign jump_start = (issue.fu == FU_JUMP);

  arithmetic_unit ARITHU (
    .alu_start (alu_start),
    .alu_op    (issue.alu_op),
    .port_a    (issue.rs1_data),
    .port_b    (issue.rs2_data),
    .rd        (issue.rd),
    .wb_au     (wb_au)
  );

  multiply_unit #(
    .MUL_LATENCY (MUL_LATENCY)
  ) MULU (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .mul_start (mul_start),
    .mul_op    (issue.mul_op),
    .rs1_data  (issue.rs1_data),
    .rs2_data  (issue.rs2_data),
    .rd        (issue.rd),
    .wb_mu     (wb_mu)
  );

  divide_unit DIVU (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush     (flush),
    .div_start (div_start),
    .div_op    (issue.div_op),
    .rs1_data  (issue.rs1_data),
    .rs2_data  (issue.rs2_data),
    .rd        (issue.rd),
    .wb_du     (wb_du),
    .busy      (busy_du)
  );

  branch_resolution_unit BRU (
    .rs1_data (issue.rs1_data),
    .rs2_data (issue.rs2_data),
    .pc       (issue.pc),
    .imm      (issue.imm),
    .br_type  (issue.br_type),
    .j_sel    (issue.j_sel),
    .br_res   (br_res)
  );

  // Hazard side sees the outcome before commit
  assign mispredict = br_start && (issue.prediction != br_res.branch_taken);
  assign brj_addr   = jump_start ? br_res.jump_addr : br_res.br_resolved_addr;

  // Interrupt is held even while the pipe is busy
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      intr_latch <= 1'b0;
    end else if (flush) begin
      intr_latch <= 1'b0;
    end else if (intr) begin
      intr_latch <= 1'b1;
    end else if (intr_taken) begin
      intr_latch <= 1'b0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      commit <= '0;
    end else if (flush) begin
      commit <= '0;
    end else begin
      commit.wb_au            <= wb_au;
      commit.wb_mu            <= wb_mu;
      commit.wb_du            <= wb_du;
      commit.pc               <= issue.pc;
      commit.branch_instr     <= br_start;
      commit.branch_taken     <= br_res.branch_taken;
      commit.prediction       <= issue.prediction;
      commit.br_resolved_addr <= br_res.br_resolved_addr;
      commit.jump_instr       <= jump_start;
      commit.jump_addr        <= br_res.jump_addr;
      commit.intr_seen        <= intr_latch;
    end
  end

endmodule

/* source/branch_resolution_unit.sv */
/*
  Branch resolution unit
  Evaluates the branch condition, resolved next address and jump target
*/
`timescale 1ns/1ns

module branch_resolution_unit (
  input  ooo_exec_pkg::word_t    rs1_data,
  input  ooo_exec_pkg::word_t    rs2_data,
  input  ooo_exec_pkg::word_t    pc,
  input  ooo_exec_pkg::word_t    imm,
  input  ooo_exec_pkg::br_type_t br_type,
  input  logic                   j_sel,
  output ooo_exec_pkg::br_res_t  br_res
);
  import ooo_exec_pkg::*;

  logic  taken;
  word_t jump_base;
  word_t jump_sum;

  always_comb begin
    case (br_type)
      BR_EQ: begin
        taken = (rs1_data == rs2_data);
      end
      BR_NE: begin
        taken = (rs1_data != rs2_data);
      end
      BR_LT: begin
        taken = ($signed(rs1_data) < $signed(rs2_data));
      end
      BR_GE: begin
        taken = ($signed(rs1_data) >= $signed(rs2_data));
      end
      BR_LTU: begin
        taken = (rs1_data < rs2_data);
      end
      BR_GEU: begin
        taken = (rs1_data >= rs2_data);
      end
      default: begin
        taken = 1'b0;
      end
    endcase
  end

  // JAL uses pc as base, JALR uses rs1
  assign jump_base = j_sel ? pc : rs1_data;
  assign jump_sum  = jump_base + imm;

  assign br_res.branch_taken     = taken;
  assign br_res.br_resolved_addr = taken ? (pc + imm) : (pc + 32'd4);
  assign br_res.jump_addr        = {jump_sum[31:1], 1'b0};

endmodule

/* source/divide_unit.sv */
/*
  Divide unit
  Iterative 32-step restoring divider on magnitudes with RISC-V sign
  and corner-case rules, busy while iterating
*/
`timescale 1ns/1ns

module divide_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   flush,
  input  logic                   div_start,
  input  ooo_exec_pkg::div_op_t  div_op,
  input  ooo_exec_pkg::word_t    rs1_data,
  input  ooo_exec_pkg::word_t    rs2_data,
  input  ooo_exec_pkg::reg_idx_t rd,
  output ooo_exec_pkg::wb_t      wb_du,
  output logic                   busy
);
  import ooo_exec_pkg::*;

  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

  div_state_t  state;
  logic [4:0]  step_cnt;
  logic        accept;
  logic        signed_op;
  word_t       abs_a, abs_b;
  div_op_t     op_q;
  reg_idx_t    rd_q;
  word_t       dividend_q, divisor_q, quo_q, rem_q;
  logic        neg_quo_q, neg_rem_q, div_zero_q, overflow_q;
  logic [32:0] trial, diff;
  word_t       quo_res, rem_res;

  // Starts are ignored mid-run
  assign accept    = div_start && !flush && (state != DIV_RUN);
  assign signed_op = (div_op == DIV_S) || (div_op == REM_S);
  assign abs_a     = (signed_op && rs1_data[31]) ? -rs1_data : rs1_data;
  assign abs_b     = (signed_op && rs2_data[31]) ? -rs2_data : rs2_data;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= DIV_IDLE;
      step_cnt <= '0;
    end else if (flush) begin
      state    <= DIV_IDLE;
      step_cnt <= '0;
    end else if (accept) begin
      state    <= DIV_RUN;
      step_cnt <= '0;
    end else begin
      case (state)
        DIV_RUN: begin
          step_cnt <= step_cnt + 5'd1;
          if (step_cnt == 5'd31) begin
            state <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          state <= DIV_IDLE;
        end
        default: begin
          state <= DIV_IDLE;
        end
      endcase
    end
  end

  // One restoring step, dividend bits shift out of quo_q as quotient bits fill in
  assign trial = {rem_q, quo_q[31]};
  assign diff  = trial - {1'b0, divisor_q};

  always_ff @(posedge CLK) begin
    if (accept) begin
      op_q       <= div_op;
      rd_q       <= rd;
      dividend_q <= rs1_data;
      divisor_q  <= abs_b;
      quo_q      <= abs_a;
      rem_q      <= '0;
      neg_quo_q  <= signed_op && (rs1_data[31] ^ rs2_data[31]);
      neg_rem_q  <= signed_op && rs1_data[31];
      div_zero_q <= (rs2_data == '0);
      overflow_q <= signed_op && (rs1_data == 32'h8000_0000) && (rs2_data == '1);
    end else if (state == DIV_RUN) begin
      quo_q <= {quo_q[30:0], ~diff[32]};
      rem_q <= diff[32] ? trial[31:0] : diff[31:0];
    end
  end

  always_comb begin
    if (div_zero_q) begin
      quo_res = '1;
      rem_res = dividend_q;
    end else if (overflow_q) begin
      quo_res = dividend_q;
      rem_res = '0;
    end else begin
      quo_res = neg_quo_q ? -quo_q : quo_q;
      rem_res = neg_rem_q ? -rem_q : rem_q;
    end
  end

  assign busy        = (state == DIV_RUN);
  assign wb_du.wen   = (state == DIV_DONE);
  assign wb_du.rd    = rd_q;
  assign wb_du.wdata = ((op_q == REM_S) || (op_q == REM_U)) ? rem_res : quo_res;

endmodule

/* source/multiply_unit.sv */
/*
  Multiply unit
  Pipelined 32x32 multiplier for MUL, MULH, MULHSU and MULHU
  Results leave MUL_LATENCY cycles after issue, one per cycle
*/
`timescale 1ns/1ns

module multiply_unit #(
  parameter int MUL_LATENCY = 2
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   flush,
  input  logic                   mul_start,
  input  ooo_exec_pkg::mul_op_t  mul_op,
  input  ooo_exec_pkg::word_t    rs1_data,
  input  ooo_exec_pkg::word_t    rs2_data,
  input  ooo_exec_pkg::reg_idx_t rd,
  output ooo_exec_pkg::wb_t      wb_mu
);
  import ooo_exec_pkg::*;

  typedef struct packed {
    reg_idx_t    rd;
    mul_op_t     op;
    logic [63:0] product;
  } mul_stage_t;

  logic [MUL_LATENCY-1:0] valid_q;
  mul_stage_t             stage_q [MUL_LATENCY];
  mul_stage_t             stage_in;
  mul_stage_t             stage_out;
  logic                   a_signed;
  logic                   b_signed;
  logic signed [32:0]     a_ext;
  logic signed [32:0]     b_ext;
  logic signed [65:0]     full_product;

  // MULHSU treats only rs1 as signed
  assign a_signed = (mul_op == MUL_HSS) || (mul_op == MUL_HSU);
  assign b_signed = (mul_op == MUL_HSS);

  assign a_ext        = {a_signed & rs1_data[31], rs1_data};
  assign b_ext        = {b_signed & rs2_data[31], rs2_data};
  assign full_product = a_ext * b_ext;

  assign stage_in.rd      = rd;
  assign stage_in.op      = mul_op;
  assign stage_in.product = full_product[63:0];

  // Valid shift register, flush drops everything in flight
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= mul_start;
      for (int i = 1; i < MUL_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge CLK) begin
    stage_q[0] <= stage_in;
    for (int i = 1; i < MUL_LATENCY; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  assign stage_out = stage_q[MUL_LATENCY-1];

  // Word select happens at the end of the pipe
  assign wb_mu.wen   = valid_q[MUL_LATENCY-1];
  assign wb_mu.rd    = stage_out.rd;
  assign wb_mu.wdata = (stage_out.op == MUL_LO) ? stage_out.product[31:0]
                                                : stage_out.product[63:32];

endmodule

/* source/arithmetic_unit.sv */
/*
  Arithmetic unit
  Single-cycle RV32 integer ALU feeding the arithmetic write-back slot
*/
`timescale 1ns/1ns

module arithmetic_unit (
  input  logic                   alu_start,
  input  ooo_exec_pkg::alu_op_t  alu_op,
  input  ooo_exec_pkg::word_t    port_a,
  input  ooo_exec_pkg::word_t    port_b,
  input  ooo_exec_pkg::reg_idx_t rd,
  output ooo_exec_pkg::wb_t      wb_au
);
  import ooo_exec_pkg::*;

  word_t      result;
  logic [4:0] shamt;

  // Only the low 5 bits shift on RV32
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        result = port_a + port_b;
      end
      ALU_SUB: begin
        result = port_a - port_b;
      end
      ALU_AND: begin
        result = port_a & port_b;
      end
      ALU_OR: begin
        result = port_a | port_b;
      end
      ALU_XOR: begin
        result = port_a ^ port_b;
      end
      ALU_SLL: begin
        result = port_a << shamt;
      end
      ALU_SRL: begin
        result = port_a >> shamt;
      end
      ALU_SRA: begin
        result = $signed(port_a) >>> shamt;
      end
      ALU_SLT: begin
        result = {31'd0, $signed(port_a) < $signed(port_b)};
      end
      ALU_SLTU: begin
        result = {31'd0, port_a < port_b};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  assign wb_au.wen   = alu_start;
  assign wb_au.rd    = rd;
  assign wb_au.wdata = result;

endmodule

/* source/ooo_exec_pkg.sv */
/*
  Execute stage types
  Shared words, unit opcodes and the packed records between issue, units and commit
*/
package ooo_exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // FU_NONE must stay zero so a cleared issue means no work
  typedef enum logic [2:0] {
    FU_NONE, FU_ALU, FU_MUL, FU_DIV, FU_BRANCH, FU_JUMP
  } fu_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // Low word, or high word with signed/unsigned operand mix
  typedef enum logic [1:0] {MUL_LO, MUL_HSS, MUL_HSU, MUL_HUU} mul_op_t;

  typedef enum logic [1:0] {DIV_S, DIV_U, REM_S, REM_U} div_op_t;

  typedef enum logic [2:0] {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} br_type_t;

  typedef struct packed {
    fu_t      fu;
    alu_op_t  alu_op;
    mul_op_t  mul_op;
    div_op_t  div_op;
    word_t    rs1_data;
    word_t    rs2_data;
    reg_idx_t rd;
    word_t    pc;
    word_t    imm;
    br_type_t br_type;
    logic     prediction;
    logic     j_sel;
  } ex_issue_t;

  typedef struct packed {
    logic     wen;
    reg_idx_t rd;
    word_t    wdata;
  } wb_t;

  typedef struct packed {
    logic  branch_taken;
    word_t br_resolved_addr;
    word_t jump_addr;
  } br_res_t;

  // One write-back slot per unit so late results can retire alongside ALU ones
  typedef struct packed {
    wb_t   wb_au;
    wb_t   wb_mu;
    wb_t   wb_du;
    word_t pc;
    logic  branch_instr;
    logic  branch_taken;
    logic  prediction;
    word_t br_resolved_addr;
    logic  jump_instr;
    word_t jump_addr;
    logic  intr_seen;
  } commit_t;

endpackage
